/* tb.f */
rtl/mips_pkg.sv
rtl/fetch_unit.sv
rtl/exec_unit.sv
rtl/reg_file.sv
rtl/mips_cpu_top.sv
dv/avalon_ram.sv
dv/cpu_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f tb.f --top-module cpu_tb -o cpu_tb_sim
	./obj_dir/cpu_tb_sim

clean:
	rm -rf obj_dir

/* dv/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    logic        clk;
    logic        rst_n;
    logic        active;
    logic        read;
    logic        waitrequest;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic [31:0] readdata;
    logic        load_en;
    logic [5:0]  load_addr;
    logic [31:0] load_data;
    logic [31:0] expected_v0;
    logic [31:0] model_v0;
    logic        active_q;
    logic        post_halt; // Set once the core has parked.
    logic [31:0] prog [64]; // Indexed by word address.
    int          next_word;

    mips_cpu_top uut (
        .clk(clk), .rst_n(rst_n), .active(active), .register_v0(register_v0),
        .address(address), .read(read), .waitrequest(waitrequest), .readdata(readdata)
    );

    avalon_ram ram (
        .clk(clk), .rst_n(rst_n), .address(address), .read(read),
        .waitrequest(waitrequest), .readdata(readdata),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // ********************
    // Instruction encoders.
    function automatic logic [31:0] r_type(input logic [4:0] rs, rt, rd, sh,
                                           input logic [5:0] fn);
        return {mips_pkg::opc_special, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] opc, input logic [4:0] rs, rt,
                                           input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    task automatic put_word(input logic [31:0] word);
        prog[6'(next_word)] = word;
        next_word++;
    endtask

    // Kind 0 is left, 1 logical right, 2 arithmetic right.
    function automatic logic [31:0] shift_word(input logic [1:0] kind,
                                               input logic [31:0] value,
                                               input logic [4:0] amount);
        logic [31:0] fill;
        fill = (kind == 2'd2 && value[31]) ? ~(32'hFFFF_FFFF >> amount) : 32'h0;
        if (kind == 2'd0) begin
            return value << amount;
        end
        return (value >> amount) | fill;
    endfunction

    // ********************
    // Reference model runs prog from the reset vector until JR $0.
    task automatic model_program(output logic [31:0] v0);
        logic [31:0] r [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ze;
        logic [31:0] se;
        for (int i = 0; i < 32; i++) begin
            r[i] = 32'h0;
        end
        pc = mips_pkg::reset_vector;
        for (int step = 0; step <= 64; step++) begin
            if (step == 64) begin
                stop_with_failure("reference model ran 64 steps without reaching JR $0");
            end
            w  = prog[pc[7:2]];
            a  = r[w[25:21]];
            b  = r[w[20:16]];
            ze = {16'h0, w[15:0]};
            se = {{16{w[15]}}, w[15:0]};
            pc = pc + 32'd4;
            if (w[31:26] == mips_pkg::opc_special && w[5:0] == mips_pkg::fn_jr) begin
                if (a == mips_pkg::halt_address) begin
                    break;
                end
                pc = a; // No delay slot.
            end else if (w[31:26] == mips_pkg::opc_special) begin
                case (w[5:0])
                    mips_pkg::fn_addu: r[w[15:11]] = a + b;
                    mips_pkg::fn_subu: r[w[15:11]] = a - b;
                    mips_pkg::fn_and:  r[w[15:11]] = a & b;
                    mips_pkg::fn_or:   r[w[15:11]] = a | b;
                    mips_pkg::fn_xor:  r[w[15:11]] = a ^ b;
                    mips_pkg::fn_sll:  r[w[15:11]] = shift_word(2'd0, b, w[10:6]);
                    mips_pkg::fn_srl:  r[w[15:11]] = shift_word(2'd1, b, w[10:6]);
                    mips_pkg::fn_sra:  r[w[15:11]] = shift_word(2'd2, b, w[10:6]);
                    mips_pkg::fn_sllv: r[w[15:11]] = shift_word(2'd0, b, a[4:0]);
                    mips_pkg::fn_srlv: r[w[15:11]] = shift_word(2'd1, b, a[4:0]);
                    mips_pkg::fn_srav: r[w[15:11]] = shift_word(2'd2, b, a[4:0]);
                    default: stop_with_failure("reference model met an unknown function code");
                endcase
            end else begin
                case (w[31:26])
                    mips_pkg::opc_addiu: r[w[20:16]] = a + se;
                    mips_pkg::opc_andi:  r[w[20:16]] = a & ze;
                    mips_pkg::opc_ori:   r[w[20:16]] = a | ze;
                    mips_pkg::opc_xori:  r[w[20:16]] = a ^ ze;
                    default: stop_with_failure("reference model met an unknown opcode");
                endcase
            end
            r[0] = 32'h0;
        end
        v0 = r[mips_pkg::reg_v0];
    endtask

    // Loads prog under reset, releases the core and waits for it to stop.
    task automatic run_program(input logic [31:0] expect_v0);
        bit seen_active;
        bit stopped;
        @(negedge clk);
        rst_n = 1'b0;
        for (int i = 1; i < next_word; i++) begin
            load_en   = 1'b1;
            load_addr = 6'(i);
            load_data = prog[6'(i)];
            @(negedge clk);
        end
        load_en = 1'b0;
        repeat (2) @(negedge clk);
        expected_v0 = expect_v0;
        rst_n       = 1'b1;
        seen_active = 1'b0;
        stopped     = 1'b0;
        for (int cycle = 0; cycle < 2000 && !stopped; cycle++) begin
            @(negedge clk);
            stopped     = seen_active && !active;
            seen_active = seen_active || active;
        end
        if (!stopped) begin
            stop_with_failure("active did not fall within 2000 cycles");
        end
        repeat (21) @(negedge clk); // Parked window.
    endtask

    // ********************
    // Programs.
    task automatic shift_program();
        next_word = 1;
        put_word(i_type(mips_pkg::opc_ori, 5'd0, 5'd8, 16'($urandom) | 16'h8000));
        put_word(r_type(5'd0, 5'd8, 5'd8, 5'd16, mips_pkg::fn_sll));
        put_word(i_type(mips_pkg::opc_ori, 5'd8, 5'd8, 16'($urandom)));
        put_word(r_type(5'd0, 5'd8, 5'd9, 5'($urandom), mips_pkg::fn_sll));
        put_word(r_type(5'd0, 5'd8, 5'd10, 5'($urandom), mips_pkg::fn_srl));
        put_word(r_type(5'd0, 5'd8, 5'd11, 5'($urandom), mips_pkg::fn_sra));
        put_word(i_type(mips_pkg::opc_ori, 5'd0, 5'd12, 16'($urandom)));
        put_word(r_type(5'd12, 5'd8, 5'd13, 5'd0, mips_pkg::fn_sllv));
        put_word(r_type(5'd12, 5'd8, 5'd14, 5'd0, mips_pkg::fn_srlv));
        put_word(r_type(5'd12, 5'd8, 5'd15, 5'd0, mips_pkg::fn_srav));
        put_word(r_type(5'd9, 5'd10, 5'd2, 5'd0, mips_pkg::fn_xor)); // Fold into $v0.
        put_word(r_type(5'd2, 5'd11, 5'd2, 5'd0, mips_pkg::fn_addu));
        put_word(r_type(5'd2, 5'd13, 5'd2, 5'd0, mips_pkg::fn_xor));
        put_word(r_type(5'd2, 5'd14, 5'd2, 5'd0, mips_pkg::fn_subu));
        put_word(r_type(5'd2, 5'd15, 5'd2, 5'd0, mips_pkg::fn_xor));
        put_word(r_type(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr));
    endtask

    task automatic alu_program();
        next_word = 1;
        put_word(i_type(mips_pkg::opc_addiu, 5'd0, 5'd8, 16'($urandom)));
        put_word(i_type(mips_pkg::opc_ori, 5'd0, 5'd9, 16'($urandom) | 16'h8000));
        put_word(r_type(5'd8, 5'd9, 5'd10, 5'd0, mips_pkg::fn_addu));
        put_word(r_type(5'd8, 5'd9, 5'd11, 5'd0, mips_pkg::fn_subu));
        put_word(r_type(5'd10, 5'd11, 5'd12, 5'd0, mips_pkg::fn_and));
        put_word(r_type(5'd10, 5'd11, 5'd13, 5'd0, mips_pkg::fn_or));
        put_word(r_type(5'd12, 5'd13, 5'd14, 5'd0, mips_pkg::fn_xor));
        put_word(i_type(mips_pkg::opc_xori, 5'd14, 5'd15, 16'($urandom) | 16'h8000));
        put_word(i_type(mips_pkg::opc_andi, 5'd15, 5'd15, 16'($urandom) | 16'h8000));
        put_word(i_type(mips_pkg::opc_ori, 5'd15, 5'd2, 16'($urandom)));
        put_word(i_type(mips_pkg::opc_addiu, 5'd0, 5'd0, 16'h1234)); // Lost in $zero.
        put_word(r_type(5'd8, 5'd9, 5'd0, 5'd0, mips_pkg::fn_addu));
        put_word(r_type(5'd2, 5'd0, 5'd2, 5'd0, mips_pkg::fn_addu));
        put_word(r_type(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr));
    endtask

    // JR to byte 24 skips words 4 and 5.
    task automatic jump_program();
        next_word = 1;
        put_word(i_type(mips_pkg::opc_addiu, 5'd0, 5'd2, 16'h0001));
        put_word(i_type(mips_pkg::opc_addiu, 5'd0, 5'd8, 16'd24));
        put_word(r_type(5'd8, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr));
        put_word(i_type(mips_pkg::opc_addiu, 5'd2, 5'd2, 16'h0100));
        put_word(i_type(mips_pkg::opc_addiu, 5'd2, 5'd2, 16'h0200));
        put_word(i_type(mips_pkg::opc_addiu, 5'd2, 5'd2, 16'h0010));
        put_word(r_type(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr));
    endtask

    initial begin
        void'($urandom(96));
        rst_n       = 1'b0;
        load_en     = 1'b0;
        load_addr   = 6'd0;
        load_data   = 32'h0;
        expected_v0 = 32'h0;
        next_word   = 1;
        repeat (2) @(negedge clk);
        // SRAV of 0xFFFF_A234 by 8.
        put_word(i_type(mips_pkg::opc_addiu, 5'd0, 5'd2, 16'hA234));
        put_word(i_type(mips_pkg::opc_addiu, 5'd0, 5'd3, 16'd8));
        put_word(r_type(5'd3, 5'd2, 5'd2, 5'd0, mips_pkg::fn_srav));
        put_word(r_type(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr));
        run_program(32'hFFFF_FFA2);
        repeat (2) begin
            shift_program();
            model_program(model_v0);
            run_program(model_v0);
        end
        alu_program();
        model_program(model_v0);
        run_program(model_v0);
        jump_program();
        model_program(model_v0);
        run_program(model_v0);
        $display("*** TEST PASSED ***");
        $finish;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            active_q  <= 1'b0;
            post_halt <= 1'b0;
        end else begin
            active_q  <= active;
            post_halt <= post_halt || (active_q && !active);
        end
    end

    // ********************
    // Checks.
    a_v0_at_halt: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(active) |-> register_v0 == expected_v0)
        else stop_with_failure($sformatf("error: time %0t register_v0 expected %h actual %h",
                                         $time, expected_v0, register_v0));

    a_bus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        read && waitrequest |=> read && $stable(address))
        else stop_with_failure("address or read changed during a waitrequest stall");

    a_reset_start: assert property (@(posedge clk)
        $rose(rst_n) |-> !active && !read ##1 read && address == mips_pkg::reset_vector)
        else stop_with_failure("core did not leave reset idle and fetch from the reset vector");

    a_parked: assert property (@(posedge clk) disable iff (!rst_n)
        post_halt |-> !active && !read && $stable(register_v0) &&
                      uut.u_fetch.state == mips_pkg::st_halt)
        else stop_with_failure("core did not stay halted with register_v0 stable");

endmodule

`default_nettype wire

/* dv/avalon_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module avalon_ram (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] address,
    input  logic        read,
    output logic        waitrequest,
    output logic [31:0] readdata,
    input  logic        load_en,
    input  logic [5:0]  load_addr,
    input  logic [31:0] load_data
);

    logic [31:0] mem [64];
    logic [1:0]  stall_count;
    logic [1:0]  stall_target; // Drawn again for every read.

    // Preload port, word addressed.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // ********************
    // Random stall of 0 to 3 cycles per read.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stall_count  <= 2'd0;
            stall_target <= 2'($urandom_range(3, 0));
        end else if (read && waitrequest) begin
            stall_count <= stall_count + 2'd1;
        end else if (read) begin
            // Read completes this cycle.
            stall_count  <= 2'd0;
            stall_target <= 2'($urandom_range(3, 0));
        end
    end

    assign waitrequest = read && (stall_count != stall_target);
    assign readdata    = mem[address[7:2]]; // Byte address to word index.

endmodule

`default_nettype wire

/* rtl/mips_cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_top (
    input  logic        clk,
    input  logic        rst_n,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] address,
    output logic        read,
    input  logic        waitrequest,
    input  logic [31:0] readdata
);

    logic [31:0] instr;
    logic        exec_strobe;
    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic        exec_wr_en;
    logic [4:0]  exec_wr_addr;
    logic [31:0] exec_wr_data;
    logic        jump;
    logic [31:0] jump_target;
    logic        halt;

    // ********************
    // Fetch side.
    fetch_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .address     (address),
        .read        (read),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .instr       (instr),
        .pc          (),            // No consumer without branches.
        .exec_strobe (exec_strobe),
        .jump        (jump),
        .jump_target (jump_target),
        .halt        (halt),
        .active      (active)
    );

    // Decode and execute.
    exec_unit u_exec (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .exec_strobe (exec_strobe),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .wr_en       (exec_wr_en),
        .wr_addr     (exec_wr_addr),
        .wr_data     (exec_wr_data),
        .jump        (jump),
        .jump_target (jump_target),
        .halt        (halt)
    );

    reg_file u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .wr_en       (exec_wr_en),
        .wr_addr     (exec_wr_addr),
        .wr_data     (exec_wr_data),
        .register_v0 (register_v0)
    );

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] register_v0
);

    logic [31:0] regs [32];

    // ********************
    // Write port.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0000_0000;
            end
        end else if (wr_en && wr_addr != 5'd0) begin // $zero stays zero.
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational read ports.
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    // Result tap for the status port.
    assign register_v0 = regs[mips_pkg::reg_v0];

    a_zero_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs_addr != 5'd0 || rs_data == 32'h0) && (rt_addr != 5'd0 || rt_data == 32'h0));

endmodule

`default_nettype wire

/* rtl/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  logic        exec_strobe,
    output logic [4:0]  rs_addr,
    output logic [4:0]  rt_addr,
    input  logic [31:0] rs_data,
    input  logic [31:0] rt_data,
    output logic        wr_en,
    output logic [4:0]  wr_addr,
    output logic [31:0] wr_data,
    output logic        jump,
    output logic [31:0] jump_target,
    output logic        halt
);

    mips_pkg::op_e op;
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  shamt;
    logic [15:0] imm;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic        is_jr;
    logic        is_imm;
    logic        stop;

    // ********************
    // Field extraction.
    assign opcode   = instr[mips_pkg::op_hi:mips_pkg::op_lo];
    assign funct    = instr[mips_pkg::fn_hi:mips_pkg::fn_lo];
    assign shamt    = instr[mips_pkg::sh_hi:mips_pkg::sh_lo];
    assign imm      = instr[mips_pkg::imm_hi:mips_pkg::imm_lo];
    assign rs_addr  = instr[mips_pkg::rs_hi:mips_pkg::rs_lo];
    assign rt_addr  = instr[mips_pkg::rt_hi:mips_pkg::rt_lo];
    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'h0000, imm};

    always_comb begin
        op = mips_pkg::op_illegal;
        case (opcode)
            mips_pkg::opc_special: begin
                case (funct)
                    mips_pkg::fn_sll:  op = mips_pkg::op_sll;
                    mips_pkg::fn_srl:  op = mips_pkg::op_srl;
                    mips_pkg::fn_sra:  op = mips_pkg::op_sra;
                    mips_pkg::fn_sllv: op = mips_pkg::op_sllv;
                    mips_pkg::fn_srlv: op = mips_pkg::op_srlv;
                    mips_pkg::fn_srav: op = mips_pkg::op_srav;
                    mips_pkg::fn_jr:   op = mips_pkg::op_jr;
                    mips_pkg::fn_addu: op = mips_pkg::op_addu;
                    mips_pkg::fn_subu: op = mips_pkg::op_subu;
                    mips_pkg::fn_and:  op = mips_pkg::op_and;
                    mips_pkg::fn_or:   op = mips_pkg::op_or;
                    mips_pkg::fn_xor:  op = mips_pkg::op_xor;
                    default:           op = mips_pkg::op_illegal;
                endcase
            end
            mips_pkg::opc_addiu: op = mips_pkg::op_addiu;
            mips_pkg::opc_andi:  op = mips_pkg::op_andi;
            mips_pkg::opc_ori:   op = mips_pkg::op_ori;
            mips_pkg::opc_xori:  op = mips_pkg::op_xori;
            default:             op = mips_pkg::op_illegal;
        endcase
    end

    // ********************
    // ALU and shifter.
    always_comb begin
        case (op)
            mips_pkg::op_addiu: wr_data = rs_data + imm_sext; // No overflow trap.
            mips_pkg::op_addu:  wr_data = rs_data + rt_data;
            mips_pkg::op_subu:  wr_data = rs_data - rt_data;
            mips_pkg::op_and:   wr_data = rs_data & rt_data;
            mips_pkg::op_or:    wr_data = rs_data | rt_data;
            mips_pkg::op_xor:   wr_data = rs_data ^ rt_data;
            mips_pkg::op_andi:  wr_data = rs_data & imm_zext;
            mips_pkg::op_ori:   wr_data = rs_data | imm_zext;
            mips_pkg::op_xori:  wr_data = rs_data ^ imm_zext;
            mips_pkg::op_sll:   wr_data = rt_data << shamt;
            mips_pkg::op_srl:   wr_data = rt_data >> shamt;
            mips_pkg::op_sra:   wr_data = $signed(rt_data) >>> shamt;
            mips_pkg::op_sllv:  wr_data = rt_data << rs_data[4:0];
            mips_pkg::op_srlv:  wr_data = rt_data >> rs_data[4:0];
            mips_pkg::op_srav:  wr_data = $signed(rt_data) >>> rs_data[4:0];
            default:            wr_data = 32'h0000_0000;
        endcase
    end

    // Immediates write rt, R-type writes rd.
    assign is_imm  = (op == mips_pkg::op_addiu) || (op == mips_pkg::op_andi) ||
                     (op == mips_pkg::op_ori) || (op == mips_pkg::op_xori);
    assign wr_addr = is_imm ? rt_addr : instr[mips_pkg::rd_hi:mips_pkg::rd_lo];

    // ********************
    // Control outputs, qualified by the strobe.
    assign is_jr       = (op == mips_pkg::op_jr);
    assign stop        = (is_jr && rs_data == mips_pkg::halt_address) ||
                         (op == mips_pkg::op_illegal);
    assign jump_target = rs_data;
    assign jump        = exec_strobe && is_jr && !stop;
    assign halt        = exec_strobe && stop;
    assign wr_en       = exec_strobe && !is_jr && (op != mips_pkg::op_illegal);

    a_halt_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(halt && wr_en));

    a_halt_no_jump: assert property (@(posedge clk) disable iff (!rst_n)
        !(jump && halt));

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic        clk,
    input  logic        rst_n,
    output logic [31:0] address,
    output logic        read,
    input  logic        waitrequest,
    input  logic [31:0] readdata,
    output logic [31:0] instr,
    output logic [31:0] pc,
    output logic        exec_strobe,
    input  logic        jump,
    input  logic [31:0] jump_target,
    input  logic        halt,
    output logic        active
);

    mips_pkg::cpu_state_e state;

    // ********************
    // Run/halt sequencer and PC.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mips_pkg::st_idle;
            pc    <= mips_pkg::reset_vector;
        end else begin
            case (state)
                mips_pkg::st_idle: state <= mips_pkg::st_fetch; // One idle cycle.
                mips_pkg::st_fetch: begin
                    if (!waitrequest) begin
                        state <= mips_pkg::st_exec;
                    end
                end
                mips_pkg::st_exec: begin
                    if (halt) begin
                        state <= mips_pkg::st_halt;
                    end else begin
                        state <= mips_pkg::st_fetch;
                        pc    <= jump ? jump_target : pc + 32'd4;
                    end
                end
                mips_pkg::st_halt: state <= mips_pkg::st_halt; // Park until reset.
                default: state <= mips_pkg::st_idle;
            endcase
        end
    end

    // Instruction register loads when the read completes.
    always_ff @(posedge clk) begin
        if (state == mips_pkg::st_fetch && !waitrequest) begin
            instr <= readdata;
        end
    end

    assign address     = pc;
    assign read        = (state == mips_pkg::st_fetch);
    assign exec_strobe = (state == mips_pkg::st_exec);
    assign active      = (state == mips_pkg::st_fetch) || (state == mips_pkg::st_exec);

    // ********************
    // Bus rules.
    a_hold_during_stall: assert property (@(posedge clk) disable iff (!rst_n)
        read && waitrequest |=> read && $stable(address));

    a_no_read_halted: assert property (@(posedge clk) disable iff (!rst_n)
        state == mips_pkg::st_halt |-> !read);

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        address[1:0] == 2'b00);

endmodule

`default_nettype wire

/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    // ********************
    // Supported operations.
    typedef enum logic [4:0] {
        op_addiu, op_addu, op_subu, op_and, op_or, op_xor,
        op_andi, op_ori, op_xori,
        op_sll, op_srl, op_sra, op_sllv, op_srlv, op_srav,
        op_jr, op_illegal
    } op_e;

    // Fetch sequencer states.
    typedef enum logic [1:0] {
        st_idle, st_fetch, st_exec, st_halt
    } cpu_state_e;

    localparam logic [31:0] reset_vector = 32'h0000_0004;
    localparam logic [31:0] halt_address = 32'h0000_0000; // JR here stops the core.
    localparam logic [4:0]  reg_v0       = 5'd2;

    // ********************
    // Instruction fields.
    localparam int op_hi = 31, op_lo = 26;
    localparam int rs_hi = 25, rs_lo = 21;
    localparam int rt_hi = 20, rt_lo = 16;
    localparam int rd_hi = 15, rd_lo = 11;
    localparam int sh_hi = 10, sh_lo = 6;
    localparam int fn_hi = 5,  fn_lo = 0;
    localparam int imm_hi = 15, imm_lo = 0;

    // Primary opcodes.
    localparam logic [5:0] opc_special = 6'h00;
    localparam logic [5:0] opc_addiu   = 6'h09;
    localparam logic [5:0] opc_andi    = 6'h0C;
    localparam logic [5:0] opc_ori     = 6'h0D;
    localparam logic [5:0] opc_xori    = 6'h0E;

    // SPECIAL function codes.
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;

endpackage

`default_nettype wire
